// File: hdl/ooo_pkg.sv
/* Out-of-order backend package
   Machine sizes, tag and index types, opcode encoding */

package ooo_pkg;

    // --------------------------------------------------
    // Machine sizes
    // --------------------------------------------------
    localparam int XLEN       = 16;
    localparam int ARCH_REGS  = 8;
    localparam int PHYS_REGS  = 16;
    localparam int ROB_DEPTH  = 8;
    localparam int MUL_STAGES = 3;
    // Tags not covered by the reset mapping
    localparam int FL_DEPTH   = PHYS_REGS - ARCH_REGS;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [XLEN-1:0] word_t;
    typedef logic [2:0]      arch_t;
    typedef logic [3:0]      ptag_t;
    typedef logic [2:0]      rob_idx_t;

    // LI passes the immediate through the ALU
    typedef enum logic [1:0] {
        OP_LI  = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2,
        OP_MUL = 2'd3
    } op_e;

endpackage

// File: hdl/rename_map.sv
/* Register rename map
   Map table plus free-list queue of physical tags */

`timescale 1ns/100ps

module rename_map (
    input  logic          clk_i,
    input  logic          rst_i,
    // Dispatch side
    input  logic          alloc_i,
    input  ooo_pkg::arch_t rd_i,
    input  ooo_pkg::arch_t rs1_i,
    input  ooo_pkg::arch_t rs2_i,
    // Retire side
    input  logic          free_i,
    input  ooo_pkg::ptag_t free_tag_i,
    // Lookups
    output ooo_pkg::ptag_t src1_tag_o,
    output ooo_pkg::ptag_t src2_tag_o,
    output ooo_pkg::ptag_t new_tag_o,
    output ooo_pkg::ptag_t old_tag_o,
    output logic          fl_empty_o
);

    typedef logic [$clog2(ooo_pkg::FL_DEPTH)-1:0] fl_ptr_t;
    typedef logic [$clog2(ooo_pkg::FL_DEPTH):0]   fl_cnt_t;

    ooo_pkg::ptag_t map_q [ooo_pkg::ARCH_REGS];
    ooo_pkg::ptag_t fl_q  [ooo_pkg::FL_DEPTH];
    fl_ptr_t        fl_head_q;
    fl_ptr_t        fl_tail_q;
    fl_cnt_t        fl_cnt_q;

    // --------------------------------------------------
    // Combinational lookups
    // --------------------------------------------------
    assign src1_tag_o = map_q[rs1_i];
    assign src2_tag_o = map_q[rs2_i];
    // Previous mapping of rd, freed when this instruction retires
    assign old_tag_o  = map_q[rd_i];
    assign new_tag_o  = fl_q[fl_head_q];
    assign fl_empty_o = (fl_cnt_q == '0);

    // --------------------------------------------------
    // Map table and free-list update
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Identity mapping, upper tags all free
            for (int r = 0; r < ooo_pkg::ARCH_REGS; r++) begin
                map_q[r] <= ooo_pkg::ptag_t'(r);
            end
            for (int i = 0; i < ooo_pkg::FL_DEPTH; i++) begin
                fl_q[i] <= ooo_pkg::ptag_t'(ooo_pkg::ARCH_REGS + i);
            end
            fl_head_q <= '0;
            fl_tail_q <= '0;
            fl_cnt_q  <= fl_cnt_t'(ooo_pkg::FL_DEPTH);
        end else begin
            if (alloc_i) begin
                map_q[rd_i] <= fl_q[fl_head_q];
                fl_head_q   <= fl_head_q + fl_ptr_t'(1);
            end
            if (free_i) begin
                fl_q[fl_tail_q] <= free_tag_i;
                fl_tail_q       <= fl_tail_q + fl_ptr_t'(1);
            end
            // Push and pop together leave the count alone
            case ({alloc_i, free_i})
                2'b10:   fl_cnt_q <= fl_cnt_q - fl_cnt_t'(1);
                2'b01:   fl_cnt_q <= fl_cnt_q + fl_cnt_t'(1);
                default: fl_cnt_q <= fl_cnt_q;
            endcase
        end
    end

endmodule

// File: hdl/dispatch_unit.sv
/* In-order dispatch
   Issue condition and operand routing to ALU or multiplier */

`timescale 1ns/100ps

module dispatch_unit (
    // Incoming instruction
    input  logic           inst_valid_i,
    input  ooo_pkg::op_e   inst_op_i,
    input  ooo_pkg::word_t inst_imm_i,
    output logic           inst_ready_o,
    // Source operands from the PRF
    input  logic           src1_ready_i,
    input  logic           src2_ready_i,
    input  ooo_pkg::word_t src1_val_i,
    input  ooo_pkg::word_t src2_val_i,
    // Resource levels
    input  logic           rob_full_i,
    input  logic           fl_empty_i,
    input  logic           alu_accept_i,
    input  logic           mul_accept_i,
    // Issue
    output logic           alloc_o,
    output logic           alu_issue_o,
    output logic           mul_issue_o,
    output ooo_pkg::word_t opa_o,
    output ooo_pkg::word_t opb_o
);

    logic is_mul;
    logic is_li;
    logic srcs_ok;
    logic unit_ok;

    assign is_mul = (inst_op_i == ooo_pkg::OP_MUL);
    assign is_li  = (inst_op_i == ooo_pkg::OP_LI);

    // No reservation station, so wait for both operands here
    assign srcs_ok = is_li || (src1_ready_i && src2_ready_i);
    assign unit_ok = is_mul ? mul_accept_i : alu_accept_i;

    assign inst_ready_o = !rob_full_i && !fl_empty_i && srcs_ok && unit_ok;

    // Fire event
    assign alloc_o     = inst_valid_i && inst_ready_o;
    assign alu_issue_o = alloc_o && !is_mul;
    assign mul_issue_o = alloc_o && is_mul;

    // Immediate replaces rs1 for LI
    assign opa_o = is_li ? inst_imm_i : src1_val_i;
    assign opb_o = src2_val_i;

endmodule

// File: hdl/phys_regfile.sv
/* Physical register file
   Values and ready bits, two read ports, written from the CDB */

`timescale 1ns/100ps

module phys_regfile (
    input  logic           clk_i,
    input  logic           rst_i,
    // Allocation of a new destination tag
    input  logic           alloc_i,
    input  ooo_pkg::ptag_t alloc_tag_i,
    // Read ports
    input  ooo_pkg::ptag_t rd1_tag_i,
    input  ooo_pkg::ptag_t rd2_tag_i,
    output ooo_pkg::word_t rd1_val_o,
    output ooo_pkg::word_t rd2_val_o,
    output logic           rd1_ready_o,
    output logic           rd2_ready_o,
    // CDB write
    input  logic           cdb_valid_i,
    input  ooo_pkg::ptag_t cdb_tag_i,
    input  ooo_pkg::word_t cdb_value_i
);

    ooo_pkg::word_t                 val_q [ooo_pkg::PHYS_REGS];
    logic [ooo_pkg::PHYS_REGS-1:0]  ready_q;

    assign rd1_val_o   = val_q[rd1_tag_i];
    assign rd2_val_o   = val_q[rd2_tag_i];
    assign rd1_ready_o = ready_q[rd1_tag_i];
    assign rd2_ready_o = ready_q[rd2_tag_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Registers read as zero after reset
            ready_q <= '1;
            for (int i = 0; i < ooo_pkg::PHYS_REGS; i++) begin
                val_q[i] <= '0;
            end
        end else begin
            // Alloc and CDB never target the same tag
            if (alloc_i) begin
                ready_q[alloc_tag_i] <= 1'b0;
            end
            if (cdb_valid_i) begin
                ready_q[cdb_tag_i] <= 1'b1;
                val_q[cdb_tag_i]   <= cdb_value_i;
            end
        end
    end

endmodule

// File: hdl/reorder_buffer.sv
/* Reorder buffer
   Circular buffer of in-flight instructions, retires in program order */

`timescale 1ns/100ps

module reorder_buffer (
    input  logic              clk_i,
    input  logic              rst_i,
    // Allocation at the tail
    input  logic              alloc_i,
    input  ooo_pkg::arch_t    alloc_rd_i,
    input  ooo_pkg::ptag_t    alloc_old_tag_i,
    output ooo_pkg::rob_idx_t tail_o,
    output logic              full_o,
    // Completion from the CDB
    input  logic              cdb_valid_i,
    input  ooo_pkg::rob_idx_t cdb_rob_i,
    input  ooo_pkg::word_t    cdb_value_i,
    // Retire port
    output logic              rt_valid_o,
    output ooo_pkg::arch_t    rt_rd_o,
    output ooo_pkg::word_t    rt_value_o,
    // Tag recycling
    output logic              free_o,
    output ooo_pkg::ptag_t    free_tag_o
);

    typedef logic [$clog2(ooo_pkg::ROB_DEPTH):0] cnt_t;

    // Entry payload
    ooo_pkg::arch_t  rd_q    [ooo_pkg::ROB_DEPTH];
    ooo_pkg::ptag_t  old_q   [ooo_pkg::ROB_DEPTH];
    ooo_pkg::word_t  val_q   [ooo_pkg::ROB_DEPTH];
    // Control state
    logic [ooo_pkg::ROB_DEPTH-1:0] done_q;
    ooo_pkg::rob_idx_t             head_q;
    ooo_pkg::rob_idx_t             tail_q;
    cnt_t                          cnt_q;
    logic                          retire;

    // --------------------------------------------------
    // Retire of the head entry
    // --------------------------------------------------
    assign retire     = (cnt_q != '0) && done_q[head_q];
    assign rt_valid_o = retire;
    assign rt_rd_o    = rd_q[head_q];
    assign rt_value_o = val_q[head_q];
    assign free_o     = retire;
    assign free_tag_o = old_q[head_q];

    assign tail_o = tail_q;
    // Depth is a power of two, top count bit means full
    assign full_o = cnt_q[$clog2(ooo_pkg::ROB_DEPTH)];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q <= '0;
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + ooo_pkg::rob_idx_t'(1);
            end
            // In-flight entry, never the slot being allocated
            if (cdb_valid_i) begin
                done_q[cdb_rob_i] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + ooo_pkg::rob_idx_t'(1);
            end
            case ({alloc_i, retire})
                2'b10:   cnt_q <= cnt_q + cnt_t'(1);
                2'b01:   cnt_q <= cnt_q - cnt_t'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q]  <= alloc_rd_i;
            old_q[tail_q] <= alloc_old_tag_i;
        end
        if (cdb_valid_i) begin
            val_q[cdb_rob_i] <= cdb_value_i;
        end
    end

endmodule

// File: hdl/exec_units.sv
/* Execution units
   One-cycle ALU and pipelined multiplier, results held until granted */

`timescale 1ns/100ps

module exec_units (
    input  logic              clk_i,
    input  logic              rst_i,
    // Issue from dispatch
    input  logic              alu_issue_i,
    input  logic              mul_issue_i,
    input  ooo_pkg::op_e      op_i,
    input  ooo_pkg::word_t    opa_i,
    input  ooo_pkg::word_t    opb_i,
    input  ooo_pkg::ptag_t    tag_i,
    input  ooo_pkg::rob_idx_t rob_i,
    output logic              alu_accept_o,
    output logic              mul_accept_o,
    // Requests toward the broadcaster
    input  logic              alu_grant_i,
    input  logic              mul_grant_i,
    output logic              alu_req_o,
    output logic              mul_req_o,
    output ooo_pkg::ptag_t    alu_tag_o,
    output ooo_pkg::ptag_t    mul_tag_o,
    output ooo_pkg::rob_idx_t alu_rob_o,
    output ooo_pkg::rob_idx_t mul_rob_o,
    output ooo_pkg::word_t    alu_value_o,
    output ooo_pkg::word_t    mul_value_o
);

    localparam int LAST = ooo_pkg::MUL_STAGES - 1;

    ooo_pkg::word_t                 alu_result;
    logic [ooo_pkg::MUL_STAGES-1:0] mul_vld_q;
    ooo_pkg::ptag_t                 mul_tag_q [ooo_pkg::MUL_STAGES];
    ooo_pkg::rob_idx_t              mul_rob_q [ooo_pkg::MUL_STAGES];
    ooo_pkg::word_t                 mul_val_q [ooo_pkg::MUL_STAGES];
    logic                           mul_adv;

    // --------------------------------------------------
    // ALU with a single result slot
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            ooo_pkg::OP_ADD: alu_result = opa_i + opb_i;
            ooo_pkg::OP_SUB: alu_result = opa_i - opb_i;
            // LI carries the immediate on opa
            default:         alu_result = opa_i;
        endcase
    end

    // Slot frees up in the cycle it wins the CDB
    assign alu_accept_o = !alu_req_o || alu_grant_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            alu_req_o <= 1'b0;
        end else if (alu_issue_i) begin
            alu_req_o <= 1'b1;
        end else if (alu_grant_i) begin
            alu_req_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alu_issue_i) begin
            alu_tag_o   <= tag_i;
            alu_rob_o   <= rob_i;
            alu_value_o <= alu_result;
        end
    end

    // --------------------------------------------------
    // Multiplier pipeline
    // --------------------------------------------------
    // Whole pipe stalls while the last stage waits for the CDB
    assign mul_adv      = !mul_vld_q[LAST] || mul_grant_i;
    assign mul_accept_o = mul_adv;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_vld_q <= '0;
        end else if (mul_adv) begin
            mul_vld_q <= {mul_vld_q[LAST-1:0], mul_issue_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_adv) begin
            // Low half of the product only
            mul_val_q[0] <= opa_i * opb_i;
            mul_tag_q[0] <= tag_i;
            mul_rob_q[0] <= rob_i;
            for (int s = 1; s < ooo_pkg::MUL_STAGES; s++) begin
                mul_val_q[s] <= mul_val_q[s-1];
                mul_tag_q[s] <= mul_tag_q[s-1];
                mul_rob_q[s] <= mul_rob_q[s-1];
            end
        end
    end

    assign mul_req_o   = mul_vld_q[LAST];
    assign mul_tag_o   = mul_tag_q[LAST];
    assign mul_rob_o   = mul_rob_q[LAST];
    assign mul_value_o = mul_val_q[LAST];

endmodule

// File: hdl/cdb_broadcaster.sv
/* CDB broadcaster
   Fixed-priority arbiter, multiplier first, registered CDB output */

`timescale 1ns/100ps

module cdb_broadcaster (
    input  logic              clk_i,
    input  logic              rst_i,
    // ALU request
    input  logic              alu_req_i,
    input  ooo_pkg::ptag_t    alu_tag_i,
    input  ooo_pkg::rob_idx_t alu_rob_i,
    input  ooo_pkg::word_t    alu_value_i,
    // Multiplier request
    input  logic              mul_req_i,
    input  ooo_pkg::ptag_t    mul_tag_i,
    input  ooo_pkg::rob_idx_t mul_rob_i,
    input  ooo_pkg::word_t    mul_value_i,
    // Grants
    output logic              alu_grant_o,
    output logic              mul_grant_o,
    // CDB
    output logic              cdb_valid_o,
    output ooo_pkg::ptag_t    cdb_tag_o,
    output ooo_pkg::rob_idx_t cdb_rob_o,
    output ooo_pkg::word_t    cdb_value_o
);

    // Multiplier wins, it stalls the deeper pipe
    assign mul_grant_o = mul_req_i;
    assign alu_grant_o = alu_req_i && !mul_req_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= alu_req_i || mul_req_i;
        end
    end

    // Winner payload, one cycle on the bus
    always_ff @(posedge clk_i) begin
        if (mul_req_i) begin
            cdb_tag_o   <= mul_tag_i;
            cdb_rob_o   <= mul_rob_i;
            cdb_value_o <= mul_value_i;
        end else if (alu_req_i) begin
            cdb_tag_o   <= alu_tag_i;
            cdb_rob_o   <= alu_rob_i;
            cdb_value_o <= alu_value_i;
        end
    end

endmodule

// File: hdl/backend_top.sv
/* Out-of-order backend top level
   Dispatch, rename, PRF, ROB, execution units and CDB broadcaster */

`timescale 1ns/100ps

module backend_top (
    input  logic           clk_i,
    input  logic           rst_i,
    // Instruction input
    input  logic           inst_valid_i,
    input  ooo_pkg::op_e   inst_op_i,
    input  ooo_pkg::arch_t inst_rd_i,
    input  ooo_pkg::arch_t inst_rs1_i,
    input  ooo_pkg::arch_t inst_rs2_i,
    input  ooo_pkg::word_t inst_imm_i,
    output logic           inst_ready_o,
    // Retire port
    output logic           rt_valid_o,
    output ooo_pkg::arch_t rt_rd_o,
    output ooo_pkg::word_t rt_value_o
);

    // --------------------------------------------------
    // Rename and PRF
    // --------------------------------------------------
    ooo_pkg::ptag_t    src1_tag, src2_tag, new_tag, old_tag;
    logic              fl_empty;
    ooo_pkg::word_t    src1_val, src2_val;
    logic              src1_ready, src2_ready;
    // ROB
    logic              rob_full;
    ooo_pkg::rob_idx_t rob_tail;
    logic              rob_free;
    ooo_pkg::ptag_t    rob_free_tag;
    // Issue
    logic              alloc, alu_issue, mul_issue;
    ooo_pkg::word_t    opa, opb;
    logic              alu_accept, mul_accept;
    // Unit requests and grants
    logic              alu_req, mul_req, alu_grant, mul_grant;
    ooo_pkg::ptag_t    alu_tag, mul_tag;
    ooo_pkg::rob_idx_t alu_rob, mul_rob;
    ooo_pkg::word_t    alu_value, mul_value;
    // CDB
    logic              cdb_valid;
    ooo_pkg::ptag_t    cdb_tag;
    ooo_pkg::rob_idx_t cdb_rob;
    ooo_pkg::word_t    cdb_value;

    rename_map u_rename (
        .clk_i(clk_i), .rst_i(rst_i),
        .alloc_i(alloc), .rd_i(inst_rd_i), .rs1_i(inst_rs1_i), .rs2_i(inst_rs2_i),
        .free_i(rob_free), .free_tag_i(rob_free_tag),
        .src1_tag_o(src1_tag), .src2_tag_o(src2_tag),
        .new_tag_o(new_tag), .old_tag_o(old_tag), .fl_empty_o(fl_empty)
    );

    dispatch_unit u_dispatch (
        .inst_valid_i(inst_valid_i), .inst_op_i(inst_op_i), .inst_imm_i(inst_imm_i),
        .inst_ready_o(inst_ready_o),
        .src1_ready_i(src1_ready), .src2_ready_i(src2_ready),
        .src1_val_i(src1_val), .src2_val_i(src2_val),
        .rob_full_i(rob_full), .fl_empty_i(fl_empty),
        .alu_accept_i(alu_accept), .mul_accept_i(mul_accept),
        .alloc_o(alloc), .alu_issue_o(alu_issue), .mul_issue_o(mul_issue),
        .opa_o(opa), .opb_o(opb)
    );

    phys_regfile u_prf (
        .clk_i(clk_i), .rst_i(rst_i),
        .alloc_i(alloc), .alloc_tag_i(new_tag),
        .rd1_tag_i(src1_tag), .rd2_tag_i(src2_tag),
        .rd1_val_o(src1_val), .rd2_val_o(src2_val),
        .rd1_ready_o(src1_ready), .rd2_ready_o(src2_ready),
        .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_value_i(cdb_value)
    );

    reorder_buffer u_rob (
        .clk_i(clk_i), .rst_i(rst_i),
        .alloc_i(alloc), .alloc_rd_i(inst_rd_i), .alloc_old_tag_i(old_tag),
        .tail_o(rob_tail), .full_o(rob_full),
        .cdb_valid_i(cdb_valid), .cdb_rob_i(cdb_rob), .cdb_value_i(cdb_value),
        .rt_valid_o(rt_valid_o), .rt_rd_o(rt_rd_o), .rt_value_o(rt_value_o),
        .free_o(rob_free), .free_tag_o(rob_free_tag)
    );

    exec_units u_exec (
        .clk_i(clk_i), .rst_i(rst_i),
        .alu_issue_i(alu_issue), .mul_issue_i(mul_issue), .op_i(inst_op_i),
        .opa_i(opa), .opb_i(opb), .tag_i(new_tag), .rob_i(rob_tail),
        .alu_accept_o(alu_accept), .mul_accept_o(mul_accept),
        .alu_grant_i(alu_grant), .mul_grant_i(mul_grant),
        .alu_req_o(alu_req), .mul_req_o(mul_req),
        .alu_tag_o(alu_tag), .mul_tag_o(mul_tag),
        .alu_rob_o(alu_rob), .mul_rob_o(mul_rob),
        .alu_value_o(alu_value), .mul_value_o(mul_value)
    );

    cdb_broadcaster u_bc (
        .clk_i(clk_i), .rst_i(rst_i),
        .alu_req_i(alu_req), .alu_tag_i(alu_tag), .alu_rob_i(alu_rob),
        .alu_value_i(alu_value),
        .mul_req_i(mul_req), .mul_tag_i(mul_tag), .mul_rob_i(mul_rob),
        .mul_value_i(mul_value),
        .alu_grant_o(alu_grant), .mul_grant_o(mul_grant),
        .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag),
        .cdb_rob_o(cdb_rob), .cdb_value_o(cdb_value)
    );

endmodule

// File: bench/backend_props.sv
/* Bound checks on the backend top level
   Retire after reset, grant exclusion, known CDB strobe */

`timescale 1ns/100ps

module backend_props (
    input logic clk_i,
    input logic rst_i,
    input logic rt_valid_i,
    input logic alu_grant_i,
    input logic mul_grant_i,
    input logic cdb_valid_i
);

    // ROB is empty right out of reset
    a_no_retire_after_reset: assert property (@(posedge clk_i) rst_i |=> !rt_valid_i)
        else $error("retire strobe high in the cycle after reset");

    // One writer on the CDB per cycle
    a_single_grant: assert property (@(posedge clk_i) disable iff (rst_i)
        !(alu_grant_i && mul_grant_i))
        else $error("ALU and multiplier granted in the same cycle");

    a_cdb_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(cdb_valid_i))
        else $error("CDB strobe has unknown bits");

endmodule

bind backend_top backend_props u_props (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .rt_valid_i(rt_valid_o),
    .alu_grant_i(alu_grant),
    .mul_grant_i(mul_grant),
    .cdb_valid_i(cdb_valid)
);

// File: bench/backend_tb.sv
/* Testbench for the out-of-order backend
   Drives instruction streams, models the architectural registers, checks retires */

`timescale 1ns/100ps

module backend_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 500;
    localparam int RAND_COUNT   = 300;

    // DUT signals
    logic           clk;
    logic           rst;
    logic           inst_valid;
    ooo_pkg::op_e   inst_op;
    ooo_pkg::arch_t inst_rd;
    ooo_pkg::arch_t inst_rs1;
    ooo_pkg::arch_t inst_rs2;
    ooo_pkg::word_t inst_imm;
    logic           inst_ready;
    logic           rt_valid;
    ooo_pkg::arch_t rt_rd;
    ooo_pkg::word_t rt_value;

    // Architectural register model and expected retire records
    ooo_pkg::word_t arch_model [ooo_pkg::ARCH_REGS];
    ooo_pkg::arch_t exp_rd [$];
    ooo_pkg::word_t exp_val [$];

    // Bookkeeping
    int          seed;
    int          chk_cnt;
    int          err_cnt;
    int          test_chk;
    int          test_err;
    logic [31:0] rnd;

    backend_top DUT (
        .clk_i(clk),
        .rst_i(rst),
        .inst_valid_i(inst_valid),
        .inst_op_i(inst_op),
        .inst_rd_i(inst_rd),
        .inst_rs1_i(inst_rs1),
        .inst_rs2_i(inst_rs2),
        .inst_imm_i(inst_imm),
        .inst_ready_o(inst_ready),
        .rt_valid_o(rt_valid),
        .rt_rd_o(rt_rd),
        .rt_value_o(rt_value)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // LI takes the immediate and the rest wrap to 16 bits
    function automatic ooo_pkg::word_t ref_result(input ooo_pkg::op_e op,
                                                  input ooo_pkg::word_t a,
                                                  input ooo_pkg::word_t b,
                                                  input ooo_pkg::word_t imm);
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_MUL: return a * b;
            default:         return imm;
        endcase
    endfunction

    task automatic finish_run();
        $display("Summary: %0d retires checked, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Registers read as zero again and nothing is outstanding
    task automatic apply_reset();
        rst        = 1'b1;
        inst_valid = 1'b0;
        for (int r = 0; r < ooo_pkg::ARCH_REGS; r++) begin
            arch_model[r] = '0;
        end
        exp_rd.delete();
        exp_val.delete();
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // Called on a falling edge and returns on the falling edge after the fire event
    task automatic issue(input ooo_pkg::op_e op, input ooo_pkg::arch_t rd,
                         input ooo_pkg::arch_t rs1, input ooo_pkg::arch_t rs2,
                         input ooo_pkg::word_t imm);
        int             waited;
        ooo_pkg::word_t result;
        waited     = 0;
        inst_valid = 1'b1;
        inst_op    = op;
        inst_rd    = rd;
        inst_rs1   = rs1;
        inst_rs2   = rs2;
        inst_imm   = imm;
        // Ready is settled well before the rising edge
        #(CLK_PERIOD/8);
        while (!inst_ready) begin
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                $display("Timeout: instruction not accepted within %0d cycles", ACCEPT_LIMIT);
                err_cnt++;
                finish_run();
            end
            @(negedge clk);
            #(CLK_PERIOD/8);
        end
        // Fires at the coming rising edge
        result         = ref_result(op, arch_model[rs1], arch_model[rs2], imm);
        arch_model[rd] = result;
        exp_rd.push_back(rd);
        exp_val.push_back(result);
        @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        waited     = 0;
        inst_valid = 1'b0;
        while (exp_rd.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Timeout: %0d instructions never retired", exp_rd.size());
                err_cnt++;
                finish_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        test_chk = chk_cnt;
        test_err = err_cnt;
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d retired, %0d errors", num, name,
                 chk_cnt - test_chk, err_cnt - test_err);
    endtask

    // --------------------------------------------------
    // Comparing process
    // --------------------------------------------------
    task automatic check_retire();
        ooo_pkg::arch_t rd;
        ooo_pkg::word_t val;
        assert (exp_rd.size() != 0) else begin
            $display("Retire at %0t with no instruction outstanding", $time);
            err_cnt++;
        end
        if (exp_rd.size() != 0) begin
            rd  = exp_rd.pop_front();
            val = exp_val.pop_front();
            chk_cnt++;
            assert (rt_rd == rd && rt_value == val) else begin
                $display("FAILED at %0t: retired r%0d = %h, expected r%0d = %h",
                         $time, rt_rd, rt_value, rd, val);
                err_cnt++;
            end
        end
    endtask

    // Samples midway through the low phase away from both edges
    initial begin
        forever begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            if (!rst && rt_valid) begin
                check_retire();
            end
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed       = 36184;
        chk_cnt    = 0;
        err_cnt    = 0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_op    = ooo_pkg::OP_LI;
        inst_rd    = '0;
        inst_rs1   = '0;
        inst_rs2   = '0;
        inst_imm   = '0;
        apply_reset();

        // Immediates into every register
        start_test();
        for (int r = 0; r < ooo_pkg::ARCH_REGS; r++) begin
            rnd = $random(seed);
            issue(ooo_pkg::OP_LI, ooo_pkg::arch_t'(r), '0, '0, rnd[15:0]);
        end
        drain();
        end_test(1, "load immediates");

        // Each step reads the previous result
        start_test();
        issue(ooo_pkg::OP_ADD, 3'd1, 3'd1, 3'd2, '0);
        issue(ooo_pkg::OP_SUB, 3'd2, 3'd1, 3'd3, '0);
        issue(ooo_pkg::OP_ADD, 3'd3, 3'd2, 3'd1, '0);
        issue(ooo_pkg::OP_SUB, 3'd1, 3'd3, 3'd2, '0);
        issue(ooo_pkg::OP_ADD, 3'd4, 3'd1, 3'd1, '0);
        issue(ooo_pkg::OP_SUB, 3'd5, 3'd4, 3'd3, '0);
        drain();
        end_test(2, "dependent add/sub chain");

        // Adds finish under the multiply latency
        start_test();
        issue(ooo_pkg::OP_MUL, 3'd1, 3'd2, 3'd3, '0);
        issue(ooo_pkg::OP_ADD, 3'd4, 3'd5, 3'd6, '0);
        issue(ooo_pkg::OP_ADD, 3'd5, 3'd6, 3'd7, '0);
        issue(ooo_pkg::OP_SUB, 3'd6, 3'd7, 3'd0, '0);
        drain();
        end_test(3, "multiply then independent adds");

        // Valid stays high across the whole stream
        start_test();
        for (int n = 0; n < RAND_COUNT; n++) begin
            rnd = $random(seed);
            issue(ooo_pkg::op_e'(rnd[1:0]), rnd[4:2], rnd[7:5], rnd[10:8], rnd[31:16]);
        end
        drain();
        end_test(4, "random stream");

        // Reset while instructions are in flight
        start_test();
        for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            issue(ooo_pkg::op_e'(rnd[1:0]), rnd[4:2], rnd[7:5], rnd[10:8], rnd[31:16]);
        end
        apply_reset();
        issue(ooo_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, '0);
        drain();
        end_test(5, "second reset");

        finish_run();
    end

endmodule

// File: compile.f
hdl/ooo_pkg.sv
hdl/rename_map.sv
hdl/dispatch_unit.sv
hdl/phys_regfile.sv
hdl/reorder_buffer.sv
hdl/exec_units.sv
hdl/cdb_broadcaster.sv
hdl/backend_top.sv
bench/backend_props.sv
bench/backend_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e

verilator --binary --timing --assert -f compile.f --top-module backend_tb \
    --Mdir obj_dir -o backend_sim

# The log decides the result, not the exit status
./obj_dir/backend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
